//--- hdl/integer_unit_pkg.sv
// Integer unit package with the machine word type and the ALU and divider operation codes
`default_nettype none

package integer_unit_pkg;

    // ------------------------------------------------------------------------
    // Word and field types
    // ------------------------------------------------------------------------

    // One RV32 machine word for operands, addresses and results
    typedef logic [31:0] data_word_t;

    // Shift count, taken from the low five bits of operand B
    typedef logic [4:0] shift_amount_t;

    // ------------------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------------------

    // Jumps and branches fill codes 0 to 7, so any code up to BRANCH_RSVD is a branch
    // The arithmetic, logic and shift codes start right after the reserved slot
    typedef enum logic [3:0] {
        JAL         = 4'd0,
        BEQ         = 4'd1,
        BNE         = 4'd2,
        BLT         = 4'd3,
        BLTU        = 4'd4,
        BGE         = 4'd5,
        BGEU        = 4'd6,
        BRANCH_RSVD = 4'd7,
        ADD         = 4'd8,
        AND         = 4'd9,
        OR          = 4'd10,
        XOR         = 4'd11,
        SLL         = 4'd12,
        SRL         = 4'd13,
        SRA         = 4'd14
    } alu_uop_t;

    // M-extension divide and remainder operations
    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_uop_t;

    // ------------------------------------------------------------------------
    // Divider control
    // ------------------------------------------------------------------------

    // States of the divider FSM
    typedef enum logic [1:0] {
        IDLE,
        PREPARE,
        ITERATE,
        FINISH
    } div_state_t;

    // The divider produces one quotient bit per iteration
    localparam int DIV_ITERATIONS = 32;

endpackage : integer_unit_pkg

`default_nettype wire

//--- hdl/arithmetic_logic_unit.sv
// Arithmetic logic unit, single cycle adder, compares, shifter, logic ops and branch detection
`default_nettype none

module arithmetic_logic_unit import integer_unit_pkg::*; (
    // Source operands, B may hold an immediate
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,

    // Address of the instruction, needed for the link value of a jump
    input  data_word_t instr_addr_i,

    // Micro operation to execute
    input  alu_uop_t   operation_i,

    // Operands and operation are valid
    input  logic       data_valid_i,

    // A compressed jump links to the address plus 2 and not plus 4
    input  logic       is_compressed_jump_i,

    // Selected result and its valid strobe
    output data_word_t result_o,
    output logic       data_valid_o,

    // High when the operation is a jump or a branch
    output logic       is_branch_o
);

    // ------------------------------------------------------------------------
    // Adder
    // ------------------------------------------------------------------------

    // Shared by ADD and every address style computation upstream
    data_word_t sum;

    assign sum = operand_a_i + operand_b_i;

    // ------------------------------------------------------------------------
    // Comparator
    // ------------------------------------------------------------------------

    logic is_equal;
    logic is_less_signed;
    logic is_less_unsigned;

    assign is_equal = (operand_a_i == operand_b_i);

    // The same pair of words can order differently once the sign bit counts
    assign is_less_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign is_less_unsigned = operand_a_i < operand_b_i;

    // ------------------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------------------

    shift_amount_t shift_amount;
    data_word_t    shift_left;
    data_word_t    shift_right_logic;
    data_word_t    shift_right_arith;

    // Only the low five bits count, so amounts above 31 wrap around
    assign shift_amount = operand_b_i[4:0];

    assign shift_left        = operand_a_i << shift_amount;
    assign shift_right_logic = operand_a_i >> shift_amount;

    // Arithmetic shift copies the sign bit into the vacated positions
    assign shift_right_arith = data_word_t'($signed(operand_a_i) >>> shift_amount);

    // ------------------------------------------------------------------------
    // Logic operations
    // ------------------------------------------------------------------------

    data_word_t and_word;
    data_word_t or_word;
    data_word_t xor_word;

    assign and_word = operand_a_i & operand_b_i;
    assign or_word  = operand_a_i | operand_b_i;
    assign xor_word = operand_a_i ^ operand_b_i;

    // ------------------------------------------------------------------------
    // Result selection
    // ------------------------------------------------------------------------

    // Link value of a jump, the address of the next instruction
    data_word_t link_addr;

    assign link_addr = is_compressed_jump_i ? (instr_addr_i + 32'd2) : (instr_addr_i + 32'd4);

    // A compare yields 0 or 1 in the low bit, which the top reads as taken
    always_comb begin : result_select
        case (operation_i)
            ADD:     result_o = sum;
            AND:     result_o = and_word;
            OR:      result_o = or_word;
            XOR:     result_o = xor_word;
            SLL:     result_o = shift_left;
            SRL:     result_o = shift_right_logic;
            SRA:     result_o = shift_right_arith;
            JAL:     result_o = link_addr;
            BEQ:     result_o = {31'b0, is_equal};
            BNE:     result_o = {31'b0, !is_equal};
            BLT:     result_o = {31'b0, is_less_signed};
            BLTU:    result_o = {31'b0, is_less_unsigned};
            BGE:     result_o = {31'b0, !is_less_signed};
            BGEU:    result_o = {31'b0, !is_less_unsigned};
            default: result_o = '0;
        endcase
    end : result_select

    // The valid strobe needs no processing here
    assign data_valid_o = data_valid_i;

    // Codes up to the reserved slot are jumps and branches
    // JAL always links to a non-zero address, so the top sees it as taken
    assign is_branch_o = (operation_i <= BRANCH_RSVD) && data_valid_i;

endmodule : arithmetic_logic_unit

`default_nettype wire

//--- hdl/division_unit.sv
// Division unit, multicycle radix-2 restoring divider for DIV, DIVU, REM and REMU
`default_nettype none

module division_unit import integer_unit_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // One cycle start strobe with the operands and the operation
    input  logic       start_i,
    input  data_word_t dividend_i,
    input  data_word_t divisor_i,
    input  div_uop_t   operation_i,

    // Quotient or remainder, valid while done_o pulses
    output data_word_t result_o,
    output logic       done_o,

    // High from the cycle after start until the done pulse ends
    output logic       busy_o
);

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------

    div_state_t state_q;
    logic [4:0] count_q;
    logic       done_q;

    div_uop_t   op_q;
    data_word_t dividend_q;
    data_word_t divisor_q;
    data_word_t quotient_q;
    data_word_t remainder_q;
    data_word_t result_q;
    logic       negate_quotient_q;
    logic       negate_remainder_q;

    // ------------------------------------------------------------------------
    // Operand preparation
    // ------------------------------------------------------------------------

    logic       is_signed_op;
    logic       dividend_negative;
    logic       divisor_negative;
    logic       divide_by_zero;
    logic       signed_overflow;
    data_word_t dividend_abs;
    data_word_t divisor_abs;

    // DIV and REM treat both operands as two's complement
    assign is_signed_op      = (op_q == DIV) || (op_q == REM);
    assign dividend_negative = is_signed_op && dividend_q[31];
    assign divisor_negative  = is_signed_op && divisor_q[31];

    assign dividend_abs = dividend_negative ? -dividend_q : dividend_q;
    assign divisor_abs  = divisor_negative ? -divisor_q : divisor_q;

    // Both corner cases have fixed results and skip the iterations
    assign divide_by_zero  = (divisor_q == '0);
    assign signed_overflow = is_signed_op && (dividend_q == 32'h8000_0000) && (divisor_q == '1);

    // ------------------------------------------------------------------------
    // Restoring step
    // ------------------------------------------------------------------------

    // Bring the next dividend bit into the partial remainder and try a subtract
    logic [32:0] remainder_shifted;
    logic [32:0] trial_diff;
    logic        trial_fits;

    assign remainder_shifted = {remainder_q, quotient_q[31]};
    assign trial_diff        = remainder_shifted - {1'b0, divisor_q};

    // No borrow means the divisor fits and the quotient bit is one
    assign trial_fits = !trial_diff[32];

    // ------------------------------------------------------------------------
    // Sign correction
    // ------------------------------------------------------------------------

    data_word_t quotient_signed;
    data_word_t remainder_signed;

    // The quotient is negative when the operand signs differ
    assign quotient_signed  = negate_quotient_q ? -quotient_q : quotient_q;

    // The remainder takes the sign of the dividend
    assign remainder_signed = negate_remainder_q ? -remainder_q : remainder_q;

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : control
        if (reset_i) begin
            state_q <= IDLE;
            count_q <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;

            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= PREPARE;
                    end
                end

                PREPARE: begin
                    count_q <= '0;
                    state_q <= (divide_by_zero || signed_overflow) ? FINISH : ITERATE;
                end

                ITERATE: begin
                    count_q <= count_q + 5'd1;

                    if (count_q == 5'(DIV_ITERATIONS - 1)) begin
                        state_q <= FINISH;
                    end
                end

                FINISH: begin
                    done_q  <= 1'b1;
                    state_q <= IDLE;
                end

                default: state_q <= IDLE;
            endcase
        end
    end : control

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : datapath
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    dividend_q <= dividend_i;
                    divisor_q  <= divisor_i;
                    op_q       <= operation_i;
                end
            end

            PREPARE: begin
                negate_quotient_q  <= 1'b0;
                negate_remainder_q <= 1'b0;
                remainder_q        <= '0;

                if (divide_by_zero) begin
                    // Quotient of all ones, remainder is the untouched dividend
                    quotient_q  <= '1;
                    remainder_q <= dividend_q;
                end else if (signed_overflow) begin
                    // Most negative value over minus one returns the dividend
                    quotient_q <= dividend_q;
                end else begin
                    // The dividend is shifted out of the quotient register MSB first
                    quotient_q         <= dividend_abs;
                    divisor_q          <= divisor_abs;
                    negate_quotient_q  <= dividend_negative ^ divisor_negative;
                    negate_remainder_q <= dividend_negative;
                end
            end

            ITERATE: begin
                quotient_q  <= {quotient_q[30:0], trial_fits};
                remainder_q <= trial_fits ? trial_diff[31:0] : remainder_shifted[31:0];
            end

            FINISH: begin
                result_q <= ((op_q == REM) || (op_q == REMU)) ? remainder_signed
                                                              : quotient_signed;
            end

            default: ;
        endcase
    end : datapath

    assign result_o = result_q;
    assign done_o   = done_q;

    // The done cycle still counts as busy, so no new issue can meet the result
    assign busy_o = (state_q != IDLE) || done_q;

endmodule : division_unit

`default_nettype wire

//--- hdl/integer_unit.sv
// Integer execution stage, issues to the ALU or the divider and registers one result per operation
`default_nettype none

module integer_unit import integer_unit_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Operands and the address of the instruction
    input  data_word_t operand_a_i,
    input  data_word_t operand_b_i,
    input  data_word_t instr_addr_i,

    // Operation codes for each unit
    input  alu_uop_t   alu_op_i,
    input  div_uop_t   div_op_i,

    // Issue strobes, at most one high per cycle
    input  logic       alu_valid_i,
    input  logic       div_valid_i,
    input  logic       is_compressed_jump_i,

    // Registered result stage
    output data_word_t result_o,
    output logic       result_valid_o,
    output logic       branch_taken_o,

    // No issue is accepted while this is high
    output logic       busy_o
);

    // ------------------------------------------------------------------------
    // Issue gating
    // ------------------------------------------------------------------------

    logic div_busy;
    logic alu_issue;
    logic div_start;

    // A strobe during a division is dropped
    assign alu_issue = alu_valid_i && !div_busy;
    assign div_start = div_valid_i && !div_busy;

    // ------------------------------------------------------------------------
    // Execution units
    // ------------------------------------------------------------------------

    data_word_t alu_result;
    logic       alu_data_valid;
    logic       alu_is_branch;

    arithmetic_logic_unit alu_inst (
        .operand_a_i          (operand_a_i),
        .operand_b_i          (operand_b_i),
        .instr_addr_i         (instr_addr_i),
        .operation_i          (alu_op_i),
        .data_valid_i         (alu_issue),
        .is_compressed_jump_i (is_compressed_jump_i),
        .result_o             (alu_result),
        .data_valid_o         (alu_data_valid),
        .is_branch_o          (alu_is_branch)
    );

    data_word_t div_result;
    logic       div_done;

    // Operand A is the dividend and operand B the divisor
    division_unit div_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .start_i     (div_start),
        .dividend_i  (operand_a_i),
        .divisor_i   (operand_b_i),
        .operation_i (div_op_i),
        .result_o    (div_result),
        .done_o      (div_done),
        .busy_o      (div_busy)
    );

    // ------------------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------------------

    // A branch is taken when the compare gave 1, or on any jump
    logic branch_taken;

    assign branch_taken = alu_is_branch && (alu_result != '0);

    // The divider holds busy through its done cycle, so the two never collide
    always_ff @(posedge clk_i) begin : output_stage
        if (reset_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
            branch_taken_o <= 1'b0;
        end else begin
            result_valid_o <= div_done || alu_data_valid;
            branch_taken_o <= !div_done && branch_taken;

            if (div_done) begin
                result_o <= div_result;
            end else if (alu_data_valid) begin
                result_o <= alu_result;
            end
        end
    end : output_stage

    assign busy_o = div_busy;

endmodule : integer_unit

`default_nettype wire

//--- tb/integer_unit_sva.sv
// Issue and result protocol assertions for the integer execution stage
`default_nettype none

module integer_unit_sva (
    input logic clk_i,
    input logic reset_i,
    input logic alu_valid_i,
    input logic div_valid_i,
    input logic result_valid_o,
    input logic branch_taken_o,
    input logic busy_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Upstream raises at most one issue strobe per cycle
    one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
        !(alu_valid_i && div_valid_i))
        else $error("both issue strobes high in one cycle");

    // An accepted ALU issue shows its result on the next cycle
    alu_result: assert property (@(posedge clk_i) disable iff (reset_i)
        $past(alu_valid_i && !busy_o) |-> result_valid_o)
        else $error("accepted ALU issue without a result");

    // The divider result appears in the cycle busy falls and at no other idle time
    div_result: assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_o |-> $past(alu_valid_i && !busy_o) || $fell(busy_o))
        else $error("result valid without an issue behind it");

    busy_start: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(busy_o) |-> $past(div_valid_i))
        else $error("busy rose without a divide issue");

    taken_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        branch_taken_o |-> result_valid_o)
        else $error("branch taken outside a result cycle");

endmodule : integer_unit_sva

bind integer_unit integer_unit_sva integer_unit_sva_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .alu_valid_i    (alu_valid_i),
    .div_valid_i    (div_valid_i),
    .result_valid_o (result_valid_o),
    .branch_taken_o (branch_taken_o),
    .busy_o         (busy_o)
);

`default_nettype wire

//--- tb/integer_unit_tb.sv
// Integer execution stage testbench with a stimulus table, a reference model and LFSR operands
`default_nettype none

module integer_unit_tb import integer_unit_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam data_word_t SIGN_BIT   = 32'h8000_0000;
    localparam int         WAIT_LIMIT = DIV_ITERATIONS + 8;

    // One line of stimulus
    // Random rows get their operands when they are applied
    typedef struct packed {
        logic       is_div;
        alu_uop_t   alu_op;
        div_uop_t   div_op;
        data_word_t a;
        data_word_t b;
        data_word_t addr;
        logic       compressed;
        logic       draw;
    } stim_row_t;

    logic       clk;
    logic       reset;
    data_word_t operand_a;
    data_word_t operand_b;
    data_word_t instr_addr;
    alu_uop_t   alu_op;
    div_uop_t   div_op;
    logic       alu_valid;
    logic       div_valid;
    logic       compressed;
    data_word_t result;
    logic       result_valid;
    logic       branch_taken;
    logic       busy;

    stim_row_t   stimulus[$];
    int          passed;
    int          failed;
    logic [31:0] lfsr_q = 32'hbebb;

    integer_unit integer_unit_inst (
        .clk_i                (clk),
        .reset_i              (reset),
        .operand_a_i          (operand_a),
        .operand_b_i          (operand_b),
        .instr_addr_i         (instr_addr),
        .alu_op_i             (alu_op),
        .div_op_i             (div_op),
        .alu_valid_i          (alu_valid),
        .div_valid_i          (div_valid),
        .is_compressed_jump_i (compressed),
        .result_o             (result),
        .result_valid_o       (result_valid),
        .branch_taken_o       (branch_taken),
        .busy_o               (busy)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end : clock_gen

    // ------------------------------------------------------------------------
    // Random operands
    // ------------------------------------------------------------------------

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    // Each call makes one step and returns the new bit
    function automatic logic lfsr_step();
        logic feedback;
        feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], feedback};
        return feedback;
    endfunction

    function automatic data_word_t random_bits(input int count);
        data_word_t word;
        word = '0;
        for (int i = 0; i < count; i++) begin
            word = {word[30:0], lfsr_step()};
        end
        return word;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic data_word_t expected_result(input stim_row_t row, output logic taken);
        shift_amount_t shamt;
        logic          signed_op;
        data_word_t    quotient;
        data_word_t    remainder;
        data_word_t    value;
        shamt = row.b[4:0];
        taken = 1'b0;
        value = '0;
        if (row.is_div) begin
            signed_op = (row.div_op == DIV) || (row.div_op == REM);
            // RISC-V fixes both corner cases instead of trapping
            if (row.b == '0) begin
                quotient  = '1;
                remainder = row.a;
            end else if (signed_op && row.a == SIGN_BIT && row.b == '1) begin
                quotient  = row.a;
                remainder = '0;
            end else if (signed_op) begin
                quotient  = data_word_t'($signed(row.a) / $signed(row.b));
                remainder = data_word_t'($signed(row.a) % $signed(row.b));
            end else begin
                quotient  = row.a / row.b;
                remainder = row.a % row.b;
            end
            value = (row.div_op == REM || row.div_op == REMU) ? remainder : quotient;
        end else begin
            case (row.alu_op)
                ADD:     value = row.a + row.b;
                AND:     value = row.a & row.b;
                OR:      value = row.a | row.b;
                XOR:     value = row.a ^ row.b;
                SLL:     value = row.a << shamt;
                SRL:     value = row.a >> shamt;
                // A logical shift of the sign extended 64 bit word fills with the sign
                SRA:     value = data_word_t'({{32{row.a[31]}}, row.a} >> shamt);
                JAL:     value = row.addr + (row.compressed ? 32'd2 : 32'd4);
                BEQ:     value = {31'b0, row.a == row.b};
                BNE:     value = {31'b0, row.a != row.b};
                // Flipping the sign bits turns a signed order into an unsigned one
                BLT:     value = {31'b0, (row.a ^ SIGN_BIT) < (row.b ^ SIGN_BIT)};
                BLTU:    value = {31'b0, row.a < row.b};
                BGE:     value = {31'b0, (row.a ^ SIGN_BIT) >= (row.b ^ SIGN_BIT)};
                BGEU:    value = {31'b0, row.a >= row.b};
                default: value = '0;
            endcase
            // A jump is always taken and a compare only when it holds
            taken = (row.alu_op == JAL) ||
                    ((row.alu_op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU}) && value[0]);
        end
        return value;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic add_alu_row(input alu_uop_t op, input data_word_t a, input data_word_t b,
                               input data_word_t addr, input logic comp, input logic draw);
        stimulus.push_back('{is_div: 1'b0, alu_op: op, div_op: DIV, a: a, b: b, addr: addr,
                             compressed: comp, draw: draw});
    endtask

    task automatic add_div_row(input div_uop_t op, input data_word_t a, input data_word_t b,
                               input logic draw);
        stimulus.push_back('{is_div: 1'b1, alu_op: ADD, div_op: op, a: a, b: b, addr: '0,
                             compressed: 1'b0, draw: draw});
    endtask

    task automatic fill_stimulus();
        add_alu_row(ADD, 32'hffff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0);
        add_alu_row(AND, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, 1'b0, 1'b0);
        add_alu_row(OR, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, 1'b0, 1'b0);
        add_alu_row(XOR, 32'hf0f0_ff00, 32'h0ff0_0ff0, '0, 1'b0, 1'b0);
        // Amounts above 31 keep only their low five bits
        add_alu_row(SLL, 32'h0000_0001, 32'h0000_0021, '0, 1'b0, 1'b0);
        add_alu_row(SRL, 32'h8000_0000, 32'h0000_001f, '0, 1'b0, 1'b0);
        add_alu_row(SRA, 32'h8000_0000, 32'h0000_0004, '0, 1'b0, 1'b0);
        add_alu_row(SRA, 32'hffff_fff0, 32'h0000_0024, '0, 1'b0, 1'b0);
        add_alu_row(BEQ, 32'h0000_1234, 32'h0000_1234, '0, 1'b0, 1'b0);
        add_alu_row(BNE, 32'h0000_1234, 32'h0000_1234, '0, 1'b0, 1'b0);
        // Minus one against one orders differently signed and unsigned
        add_alu_row(BLT, 32'hffff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0);
        add_alu_row(BLTU, 32'hffff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0);
        add_alu_row(BGE, 32'hffff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0);
        add_alu_row(BGEU, 32'hffff_ffff, 32'h0000_0001, '0, 1'b0, 1'b0);
        add_alu_row(JAL, '0, '0, 32'h0000_1000, 1'b0, 1'b0);
        add_alu_row(JAL, '0, '0, 32'h0000_1000, 1'b1, 1'b0);
        add_alu_row(ADD, '0, '0, '0, 1'b0, 1'b1);
        add_alu_row(SRA, '0, '0, '0, 1'b0, 1'b1);
        add_alu_row(BLT, '0, '0, '0, 1'b0, 1'b1);
        add_alu_row(BGEU, '0, '0, '0, 1'b0, 1'b1);
        add_div_row(DIV, 32'hffff_ff9c, 32'h0000_0007, 1'b0);
        add_div_row(REM, 32'hffff_ff9c, 32'h0000_0007, 1'b0);
        add_div_row(REM, 32'h0000_0064, 32'hffff_fff9, 1'b0);
        add_div_row(DIVU, 32'hffff_ffff, 32'h0000_0003, 1'b0);
        add_div_row(REMU, 32'hffff_ffff, 32'h0000_000a, 1'b0);
        add_div_row(DIV, 32'h0000_0123, '0, 1'b0);
        add_div_row(DIVU, 32'h8000_0123, '0, 1'b0);
        add_div_row(REM, 32'h8000_0123, '0, 1'b0);
        add_div_row(REMU, 32'h0000_0123, '0, 1'b0);
        add_div_row(DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        add_div_row(REM, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        add_div_row(DIV, '0, '0, 1'b1);
        add_div_row(DIVU, '0, '0, 1'b1);
        add_div_row(REM, '0, '0, 1'b1);
        add_div_row(REMU, '0, '0, 1'b1);
        // ALU work right after the divider goes idle
        add_alu_row(XOR, '0, '0, '0, 1'b0, 1'b1);
        add_alu_row(JAL, '0, '0, 32'h0000_2ffc, 1'b1, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Issue and check
    // ------------------------------------------------------------------------

    task automatic run_row(input int index, input stim_row_t row, output logic timed_out);
        data_word_t want;
        logic       want_taken;
        logic       saw_busy;
        logic       busy_dropped;
        logic       row_ok;
        int         cycles;
        want         = expected_result(row, want_taken);
        timed_out    = 1'b0;
        saw_busy     = 1'b0;
        busy_dropped = 1'b0;
        row_ok       = 1'b1;
        cycles       = 0;
        @(posedge clk);
        operand_a  <= row.a;
        operand_b  <= row.b;
        instr_addr <= row.addr;
        alu_op     <= row.alu_op;
        div_op     <= row.div_op;
        compressed <= row.compressed;
        alu_valid  <= !row.is_div;
        div_valid  <= row.is_div;
        @(posedge clk);
        alu_valid <= 1'b0;
        div_valid <= 1'b0;
        // Outputs are sampled on the falling edge away from the register updates
        do begin
            @(negedge clk);
            cycles++;
            saw_busy = saw_busy || busy;
            // A division keeps busy high in every cycle before its result
            if (row.is_div && !result_valid && !busy) begin
                busy_dropped = 1'b1;
            end
        end while (!result_valid && cycles < WAIT_LIMIT);
        if (!result_valid) begin
            $display("row %0d: no result after %0d cycles, the DUT seems stuck", index, cycles);
            timed_out = 1'b1;
            failed++;
            return;
        end
        if (result != want) begin
            $display("ERR %0t: row %0d result %h, expected %h", $time, index, result, want);
            row_ok = 1'b0;
        end
        if (branch_taken != want_taken) begin
            $display("ERR %0t: row %0d branch_taken %b, expected %b", $time, index,
                     branch_taken, want_taken);
            row_ok = 1'b0;
        end
        if (!row.is_div && cycles != 1) begin
            $display("ERR %0t: row %0d ALU latency %0d, expected 1", $time, index, cycles);
            row_ok = 1'b0;
        end
        if (row.is_div != saw_busy) begin
            $display("ERR %0t: row %0d busy seen %b, expected %b", $time, index, saw_busy,
                     row.is_div);
            row_ok = 1'b0;
        end
        if (busy_dropped) begin
            $display("ERR %0t: row %0d busy fell before the result", $time, index);
            row_ok = 1'b0;
        end
        if (row.is_div && busy) begin
            $display("ERR %0t: row %0d busy still high with the result", $time, index);
            row_ok = 1'b0;
        end
        if (row_ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("row %0d %s a=%h b=%h: %s", index, row.is_div ? "div" : "alu", row.a, row.b,
                 row_ok ? "ok" : "failed");
    endtask

    initial begin : main
        stim_row_t row;
        logic      hung;
        logic      reset_ok;
        reset      <= 1'b1;
        operand_a  <= '0;
        operand_b  <= '0;
        instr_addr <= '0;
        alu_op     <= ADD;
        div_op     <= DIV;
        alu_valid  <= 1'b0;
        div_valid  <= 1'b0;
        compressed <= 1'b0;
        passed = 0;
        failed = 0;
        hung   = 1'b0;
        fill_stimulus();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        reset_ok = !(result_valid || branch_taken || busy) && (result == '0);
        if (!reset_ok) begin
            $display("ERR %0t: outputs not idle after reset", $time);
            failed++;
        end else begin
            passed++;
        end
        $display("reset: %s", reset_ok ? "ok" : "failed");
        for (int i = 0; i < stimulus.size() && !hung; i++) begin
            row = stimulus[i];
            if (row.draw) begin
                row.a = random_bits(32);
                // Short divisors give quotients with many significant bits
                if (row.is_div) begin
                    row.b = random_bits(12);
                end else begin
                    row.b = random_bits(32);
                end
            end
            run_row(i, row, hung);
        end
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && !hung) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end : main

endmodule : integer_unit_tb

`default_nettype wire

//--- all.f
hdl/integer_unit_pkg.sv
hdl/arithmetic_logic_unit.sv
hdl/division_unit.sv
hdl/integer_unit.sv
tb/integer_unit_sva.sv
tb/integer_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the integer unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module integer_unit_tb -f all.f

output="$(./obj_dir/Vinteger_unit_tb)"
echo "$output"

# The run passes only when the testbench printed its pass line
grep -qx "STATUS: PASS" <<< "$output"
